//--- project.f
verilog/display_pkg.sv
verilog/segment_encoder.sv
verilog/magnitude_bcd_converter.sv
verilog/spi_frame_shifter.sv
verilog/display_sequencer.sv
verilog/max7219_display.sv
testbench/spi_frame_monitor.sv
testbench/tb_max7219_display.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_max7219_display
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_TEXT := ALL TESTS PASSED

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_max7219_display.sv
`timescale 1ns/1ps

module tb_max7219_display;
    import display_pkg::*;

    localparam int FRAME_TIMEOUT = 400;

    logic           clk;
    logic           reset;
    display_value_t value;
    logic           mosi;
    logic           sclk;
    logic           sel;
    logic [15:0]    mon_frame;
    int             mon_edges;
    int             mon_count;
    int             mon_errors;

    int          error_count;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    int          frames_taken;
    bit          timed_out;
    logic [31:0] rand_state;
    logic [15:0] setup_words [4] = '{16'h0900, 16'h0A04, 16'h0B07, 16'h0C01};

    max7219_display uut (
        .clk  (clk),
        .reset(reset),
        .value(value),
        .mosi (mosi),
        .sclk (sclk),
        .sel  (sel)
    );

    spi_frame_monitor monitor (
        .clk            (clk),
        .mosi           (mosi),
        .sclk           (sclk),
        .sel            (sel),
        .frame_data     (mon_frame),
        .edge_count     (mon_edges),
        .frame_count    (mon_count),
        .protocol_errors(mon_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Segment bits a to g, a highest
    function automatic logic [6:0] numeral_segments(input int digit);
        case (digit)
            0: return 7'h7E;
            1: return 7'h30;
            2: return 7'h6D;
            3: return 7'h79;
            4: return 7'h33;
            5: return 7'h5B;
            6: return 7'h5F;
            7: return 7'h70;
            8: return 7'h7F;
            9: return 7'h7B;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic [15:0] expected_frame(input display_value_t v, input int reg_num);
        longint     mag;
        logic [7:0] data;
        mag = v;
        if (mag < 0) begin
            mag = -mag;
        end
        if (mag > 999999) begin
            mag = 999999;
        end
        repeat (reg_num - 1) begin
            mag = mag / 10;
        end
        if (reg_num <= 6) begin
            data = {1'b0, numeral_segments(int'(mag % 10))};
        end else if (reg_num == 7 && v < 0) begin
            data = 8'h01;
        end else begin
            data = 8'h00;
        end
        if (reg_num == 3) begin
            data[7] = 1'b1;
        end
        return {reg_num[7:0], data};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count + mon_errors;
    endtask

    task automatic finish_test(input string name);
        int failures;
        failures = error_count + mon_errors - errors_at_start;
        tests_run++;
        if (failures > 0) begin
            tests_failed++;
            $display("Test %s: %0d errors", name, failures);
        end else if (timed_out) begin
            tests_failed++;
            $display("Test %s: not run, the DUT stopped sending frames", name);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    task automatic next_frame(output logic [15:0] data, output int edges);
        int waited;
        waited = 0;
        data = '0;
        edges = 0;
        while (mon_count == frames_taken && waited < FRAME_TIMEOUT && !timed_out) begin
            @(posedge clk);
            waited++;
        end
        if (!timed_out && mon_count == frames_taken) begin
            $display("Timeout: no frame came out on the serial lines within %0d cycles",
                     FRAME_TIMEOUT);
            timed_out = 1'b1;
            error_count++;
        end else if (!timed_out) begin
            data = mon_frame;
            edges = mon_edges;
            frames_taken++;
        end
    endtask

    task automatic take_frame(input string name, input logic [15:0] expected,
                              input logic [15:0] mask);
        logic [15:0] data;
        int          edges;
        next_frame(data, edges);
        if (!timed_out) begin
            compare_value(name, expected & mask, data & mask);
            compare_value("sclk edges", 32'd16, edges);
        end
    endtask

    // A sweep that is not compared in full still has to keep the register order
    task automatic check_sweep(input display_value_t v, input bit full);
        int r;
        for (r = 1; r <= 8 && !timed_out; r++) begin
            if (full) begin
                take_frame("frame", expected_frame(v, r), 16'hFFFF);
            end else begin
                take_frame("frame address", expected_frame(v, r), 16'hFF00);
            end
        end
    endtask

    task automatic show_value(input display_value_t v);
        @(posedge clk);
        value <= v;
        check_sweep(v, 1'b0);
        check_sweep(v, 1'b1);
    endtask

    initial begin
        int i;
        reset <= 1'b1;
        value <= '0;
        error_count = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        frames_taken = 0;
        timed_out = 1'b0;
        rand_state = 32'h8b74;

        start_test();
        for (i = 0; i < 9; i++) begin
            @(posedge clk);
            if (i == 7) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            compare_value("sel", 32'd1, sel);
            compare_value("sclk", 32'd0, sclk);
        end
        @(posedge clk);
        compare_value("frame count", 32'd0, mon_count);
        finish_test("idle after reset");

        start_test();
        for (i = 0; i < 4 && !timed_out; i++) begin
            take_frame("setup frame", setup_words[i], 16'hFFFF);
        end
        finish_test("setup sequence");

        start_test();
        for (i = 0; i < 3; i++) begin
            check_sweep('0, 1'b0);
        end
        finish_test("sweep order");

        start_test();
        show_value('0);
        for (i = 0; i < 3; i++) begin
            rand_state = lcg_step(rand_state);
            show_value(display_value_t'((rand_state >> 8) % 32'd1000000));
        end
        finish_test("positive values");

        start_test();
        for (i = 0; i < 3; i++) begin
            rand_state = lcg_step(rand_state);
            show_value(-display_value_t'(1 + (rand_state >> 8) % 32'd999999));
        end
        finish_test("negative values");

        start_test();
        show_value(display_value_t'(1200000));
        show_value(24'h800000);
        show_value(display_value_t'(999999));
        show_value(display_value_t'(-999999));
        finish_test("saturation");

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count + mon_errors);
        if (tests_failed == 0 && error_count + mon_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/spi_frame_monitor.sv
`timescale 1ns/1ps

module spi_frame_monitor (
    input  logic        clk,
    input  logic        mosi,
    input  logic        sclk,
    input  logic        sel,
    output logic [15:0] frame_data,
    output int          edge_count,
    output int          frame_count,
    output int          protocol_errors
);
    logic [15:0] shift = '0;
    logic [15:0] last_frame = '0;
    int          edges = 0;
    int          last_edges = 0;
    int          frames = 0;
    int          errors = 0;
    logic        prev_sclk = 1'b0;
    logic        prev_sel = 1'b1;

    assign frame_data = last_frame;
    assign edge_count = last_edges;
    assign frame_count = frames;
    assign protocol_errors = errors;

    // The DUT changes its lines on rising clk edges, so the falling edge sees them settled
    always @(negedge clk) begin
        prev_sclk <= sclk;
        prev_sel <= sel;
        if (sel != prev_sel) begin
            assert (!sclk) else begin
                $display("Fail at %0t ns: sclk expected 0 got 1 while sel changed", $time);
                errors <= errors + 1;
            end
        end
        if (!sel && prev_sel) begin
            shift <= '0;
            edges <= 0;
        end else if (!sel && sclk && !prev_sclk) begin
            // Most significant bit arrives first
            shift <= {shift[14:0], mosi};
            edges <= edges + 1;
        end else if (sel && !prev_sel) begin
            last_frame <= shift;
            last_edges <= edges;
            frames <= frames + 1;
        end
    end

endmodule

//--- verilog/max7219_display.sv
`timescale 1ns/1ps

module max7219_display (
    input  logic                        clk,
    input  logic                        reset,
    input  display_pkg::display_value_t value,
    output logic                        mosi,
    output logic                        sclk,
    output logic                        sel
);
    import display_pkg::*;

    logic        convert_start;
    logic        convert_done;
    bcd_t        bcd;
    logic        negative;
    digit_code_t digit_code;
    segments_t   segments;
    logic        frame_start;
    frame_t      frame;
    logic        frame_done;

    display_sequencer sequencer (
        .clk          (clk),
        .reset        (reset),
        .convert_start(convert_start),
        .convert_done (convert_done),
        .bcd          (bcd),
        .negative     (negative),
        .digit_code   (digit_code),
        .segments     (segments),
        .frame_start  (frame_start),
        .frame        (frame),
        .frame_done   (frame_done)
    );

    magnitude_bcd_converter converter (
        .clk          (clk),
        .reset        (reset),
        .convert_start(convert_start),
        .value        (value),
        .bcd          (bcd),
        .negative     (negative),
        .convert_done (convert_done)
    );

    segment_encoder encoder (
        .digit_code(digit_code),
        .segments  (segments)
    );

    spi_frame_shifter shifter (
        .clk        (clk),
        .reset      (reset),
        .frame_start(frame_start),
        .frame      (frame),
        .mosi       (mosi),
        .sclk       (sclk),
        .sel        (sel),
        .frame_done (frame_done)
    );

endmodule

//--- verilog/display_sequencer.sv
`timescale 1ns/1ps

module display_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     convert_start,
    input  logic                     convert_done,
    input  display_pkg::bcd_t        bcd,
    input  logic                     negative,
    output display_pkg::digit_code_t digit_code,
    input  display_pkg::segments_t   segments,
    output logic                     frame_start,
    output display_pkg::frame_t      frame,
    input  logic                     frame_done
);
    import display_pkg::*;

    sequencer_state_t          state;
    logic                      in_setup;
    logic [SETUP_CNT_BITS-1:0] setup_cnt;
    reg_addr_t                 digit_reg;
    frame_t                    setup_frame;
    logic                      dp;

    always_comb begin
        case (setup_cnt)
            2'd0:    setup_frame = SETUP_DECODE;
            2'd1:    setup_frame = SETUP_INTENSITY;
            2'd2:    setup_frame = SETUP_SCAN_LIMIT;
            default: setup_frame = SETUP_NORMAL_OP;
        endcase
    end

    // Registers 1 to 6 take the BCD digits, 7 the sign and 8 stays blank
    always_comb begin
        case (digit_reg)
            8'd1:    digit_code = bcd[3:0];
            8'd2:    digit_code = bcd[7:4];
            8'd3:    digit_code = bcd[11:8];
            8'd4:    digit_code = bcd[15:12];
            8'd5:    digit_code = bcd[19:16];
            8'd6:    digit_code = bcd[23:20];
            8'd7:    digit_code = negative ? CODE_MINUS : CODE_BLANK;
            default: digit_code = CODE_BLANK;
        endcase
    end

    assign dp = digit_reg == DP_DIGIT_REG;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEND_SETUP;
            in_setup <= 1'b1;
            setup_cnt <= '0;
            digit_reg <= FIRST_DIGIT_REG;
            frame_start <= 1'b0;
            convert_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            convert_start <= 1'b0;
            case (state)
                SEND_SETUP: begin
                    frame_start <= 1'b1;
                    state <= WAIT_FRAME;
                end
                // convert_start is high for exactly this one cycle
                START_CONVERT: state <= WAIT_CONVERT;
                WAIT_CONVERT: begin
                    if (convert_done) begin
                        digit_reg <= FIRST_DIGIT_REG;
                        state <= SEND_DIGIT;
                    end
                end
                SEND_DIGIT: begin
                    frame_start <= 1'b1;
                    state <= WAIT_FRAME;
                end
                WAIT_FRAME: begin
                    if (frame_done) begin
                        if (in_setup) begin
                            if (setup_cnt == SETUP_CNT_BITS'(SETUP_FRAMES - 1)) begin
                                in_setup <= 1'b0;
                                convert_start <= 1'b1;
                                state <= START_CONVERT;
                            end else begin
                                setup_cnt <= setup_cnt + 1'b1;
                                state <= SEND_SETUP;
                            end
                        end else if (digit_reg == LAST_DIGIT_REG) begin
                            convert_start <= 1'b1;
                            state <= START_CONVERT;
                        end else begin
                            digit_reg <= digit_reg + 1'b1;
                            state <= SEND_DIGIT;
                        end
                    end
                end
                default: state <= SEND_SETUP;
            endcase
        end
    end

    // Frame is loaded in the same cycle that frame_start is raised
    always_ff @(posedge clk) begin
        if (state == SEND_SETUP) begin
            frame <= setup_frame;
        end else if (state == SEND_DIGIT) begin
            frame <= {digit_reg, dp, segments};
        end
    end

endmodule

//--- verilog/spi_frame_shifter.sv
`timescale 1ns/1ps

module spi_frame_shifter (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_start,
    input  display_pkg::frame_t frame,
    output logic                mosi,
    output logic                sclk,
    output logic                sel,
    output logic                frame_done
);
    import display_pkg::*;

    typedef enum logic [2:0] {IDLE, SELECT, SHIFT, GAP, DONE} shifter_state_t;

    shifter_state_t          state;
    frame_t                  shift_reg;
    logic [HALF_CNT_BITS-1:0] half_cnt;
    logic [BIT_CNT_BITS-1:0]  bit_cnt;
    logic [GAP_CNT_BITS-1:0]  gap_cnt;
    logic                    half_end;
    logic                    gap_end;

    assign half_end = half_cnt == HALF_CNT_BITS'(SCLK_HALF_CYCLES - 1);
    assign gap_end = gap_cnt == GAP_CNT_BITS'(SEL_GAP_CYCLES - 1);
    assign frame_done = state == DONE;

    // SELECT is the low half of the first bit, SHIFT covers the remaining 31 half periods
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            sel <= 1'b1;
            sclk <= 1'b0;
            mosi <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
            gap_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_start) begin
                        sel <= 1'b0;
                        mosi <= frame[FRAME_BITS-1];
                        half_cnt <= '0;
                        bit_cnt <= '0;
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    half_cnt <= half_cnt + 1'b1;
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk <= 1'b1;
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    half_cnt <= half_cnt + 1'b1;
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk <= ~sclk;
                        // Falling edge, so the next bit goes out or the frame ends
                        if (sclk) begin
                            if (bit_cnt == BIT_CNT_BITS'(FRAME_BITS - 1)) begin
                                sel <= 1'b1;
                                mosi <= 1'b0;
                                gap_cnt <= '0;
                                state <= GAP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                                mosi <= shift_reg[FRAME_BITS-2];
                            end
                        end
                    end
                end
                GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_end) begin
                        state <= DONE;
                    end
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && frame_start) begin
            shift_reg <= frame;
        end else if (state == SHIFT && half_end && sclk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

//--- verilog/magnitude_bcd_converter.sv
`timescale 1ns/1ps

module magnitude_bcd_converter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        convert_start,
    input  display_pkg::display_value_t value,
    output display_pkg::bcd_t           bcd,
    output logic                        negative,
    output logic                        convert_done
);
    import display_pkg::*;

    logic [$bits(display_value_t)-1:0] abs_value;
    magnitude_t                        magnitude;
    magnitude_t                        binary;
    logic                              busy;
    logic [STEP_CNT_BITS-1:0]          step_cnt;

    // Adds 3 to every BCD digit of 5 or more ahead of the next shift
    function automatic bcd_t add_three(input bcd_t digits);
        bcd_t adjusted;
        integer i;
        adjusted = digits;
        for (i = 0; i < BCD_DIGITS; i = i + 1) begin
            if (adjusted[4*i +: 4] >= 4'd5) begin
                adjusted[4*i +: 4] = adjusted[4*i +: 4] + 4'd3;
            end
        end
        return adjusted;
    endfunction

    // The most negative input has no 24-bit positive twin, but its bit pattern
    // read as unsigned is already the right magnitude
    assign abs_value = (value < 0) ? -value : value;
    assign magnitude = (abs_value > {4'b0, MAX_MAGNITUDE}) ? MAX_MAGNITUDE
                                                           : abs_value[19:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            step_cnt <= '0;
            convert_done <= 1'b0;
        end else begin
            convert_done <= 1'b0;
            if (convert_start) begin
                busy <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == STEP_CNT_BITS'(BCD_STEPS - 1)) begin
                    busy <= 1'b0;
                    convert_done <= 1'b1;
                end
            end
        end
    end

    // One shift-and-add-3 step per cycle, binary bits enter bcd from the top
    always_ff @(posedge clk) begin
        if (convert_start) begin
            negative <= value < 0;
            binary <= magnitude;
            bcd <= '0;
        end else if (busy) begin
            {bcd, binary} <= {add_three(bcd), binary} << 1;
        end
    end

endmodule

//--- verilog/segment_encoder.sv
`timescale 1ns/1ps

module segment_encoder (
    input  display_pkg::digit_code_t digit_code,
    output display_pkg::segments_t   segments
);
    import display_pkg::*;

    // Bit 6 is segment a, bit 0 is segment g (the middle bar)
    always_comb begin
        case (digit_code)
            4'd0:       segments = 7'b1111110;
            4'd1:       segments = 7'b0110000;
            4'd2:       segments = 7'b1101101;
            4'd3:       segments = 7'b1111001;
            4'd4:       segments = 7'b0110011;
            4'd5:       segments = 7'b1011011;
            4'd6:       segments = 7'b1011111;
            4'd7:       segments = 7'b1110000;
            4'd8:       segments = 7'b1111111;
            4'd9:       segments = 7'b1111011;
            CODE_MINUS: segments = 7'b0000001;
            CODE_BLANK: segments = 7'b0000000;
            // Hex letters, left in for debug displays
            4'd12:      segments = 7'b1001110;
            4'd13:      segments = 7'b0111101;
            4'd14:      segments = 7'b1001111;
            4'd15:      segments = 7'b1000111;
            default:    segments = 7'b0000000;
        endcase
    end

endmodule

//--- verilog/display_pkg.sv
package display_pkg;

    typedef logic signed [23:0] display_value_t;
    typedef logic [19:0]        magnitude_t;
    typedef logic [23:0]        bcd_t;
    typedef logic [3:0]         digit_code_t;
    typedef logic [6:0]         segments_t;
    typedef logic [7:0]         reg_addr_t;
    typedef logic [15:0]        frame_t;

    localparam magnitude_t MAX_MAGNITUDE = 20'd999999;
    localparam int BCD_DIGITS = 6;
    localparam int BCD_STEPS = 20;

    // Serial timing, counted in clk cycles
    localparam int FRAME_BITS = 16;
    localparam int SCLK_HALF_CYCLES = 4;
    localparam int SEL_GAP_CYCLES = 4;

    localparam int HALF_CNT_BITS = $clog2(SCLK_HALF_CYCLES);
    localparam int GAP_CNT_BITS = $clog2(SEL_GAP_CYCLES);
    localparam int BIT_CNT_BITS = $clog2(FRAME_BITS);
    localparam int STEP_CNT_BITS = $clog2(BCD_STEPS);

    // Setup commands, register address in the upper byte
    localparam frame_t SETUP_DECODE = 16'h0900;
    localparam frame_t SETUP_INTENSITY = 16'h0A04;
    localparam frame_t SETUP_SCAN_LIMIT = 16'h0B07;
    localparam frame_t SETUP_NORMAL_OP = 16'h0C01;
    localparam int SETUP_FRAMES = 4;
    localparam int SETUP_CNT_BITS = $clog2(SETUP_FRAMES);

    // Digit registers 1 to 8, register 1 is the rightmost digit
    localparam reg_addr_t FIRST_DIGIT_REG = 8'd1;
    localparam reg_addr_t LAST_DIGIT_REG = 8'd8;
    localparam reg_addr_t DP_DIGIT_REG = 8'd3;

    localparam digit_code_t CODE_MINUS = 4'd10;
    localparam digit_code_t CODE_BLANK = 4'd11;

    typedef enum logic [2:0] {
        SEND_SETUP,
        START_CONVERT,
        WAIT_CONVERT,
        SEND_DIGIT,
        WAIT_FRAME
    } sequencer_state_t;

endpackage
